/* kb_verify.f */
+incdir+source
+incdir+verif
source/md5_pkg.sv
source/cipher_pkg.sv
source/md5_core.sv
source/md5_arbiter.sv
source/xtea_decrypt.sv
source/key_check.sv
source/kb_verify_top.sv
verif/kb_verify_tb.sv

/* verif/tb_models.svh */
`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

// md5 compression of one padded block, digest A in the low word
function automatic logic [127:0] md5_ref(input logic [447:0] kb);
    logic [31:0] m [16];
    logic [31:0] a, b, c, d, f, t, d_old;
    logic [4:0]  s;
    int          i;
    for (i = 0; i < 14; i++) begin
        m[i] = kb[32*i +: 32];                  // lowest slice is word 0
    end
    m[14] = 32'h0;
    m[15] = 32'h8000_0000;                      // pad bit only, no length field
    a = md5_iv[0];
    b = md5_iv[1];
    c = md5_iv[2];
    d = md5_iv[3];
    for (i = 0; i < 64; i++) begin
        if (i < 16) f = (b & c) | (~b & d);     // F
        else if (i < 32) f = (d & b) | (~d & c); // G
        else if (i < 48) f = b ^ c ^ d;         // H
        else f = c ^ (b | ~d);                  // I
        t     = a + f + md5_k(6'(i)) + m[md5_g(6'(i))];
        s     = md5_s(6'(i));
        d_old = d;
        d     = c;
        c     = b;
        b     = b + ((t << s) | (t >> (32 - s)));
        a     = d_old;
    end
    return {d + md5_iv[3], c + md5_iv[2], b + md5_iv[1], a + md5_iv[0]};
endfunction

// forward xtea on one 64-bit block, v0 in the low half
function automatic logic [63:0] xtea_enc(input logic [3:0][31:0] k, input logic [63:0] blk);
    logic [31:0] v0, v1, sum;
    int          r;
    v0  = blk[31:0];
    v1  = blk[63:32];
    sum = 32'h0;
    for (r = 0; r < `XTEA_ROUNDS; r++) begin
        v0  = v0 + ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum[1:0]]));
        sum = sum + xtea_delta;
        v1  = v1 + ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[sum[12:11]]));
    end
    return {v1, v0};
endfunction

// digest encrypted under itself, both halves
function automatic logic [127:0] enc_hash(input logic [127:0] dg);
    return {xtea_enc(dg, dg[127:64]), xtea_enc(dg, dg[63:0])};
endfunction

`endif

/* verif/kb_verify_tb.sv */
`timescale 1ns/1ps
`include "kb_verify_config.svh"

module kb_verify_tb;
    import md5_pkg::*;
    import cipher_pkg::*;

    `include "tb_models.svh"

    logic          clk, rst, stall;
    logic          start_0, start_1, done_0, done_1, valid_0, valid_1;
    logic [447:0]  kb_0, kb_1;
    cipher_block_u in_buf_0, in_buf_1;
    logic [127:0]  key_0, key_1;

    logic [128:0]  exp_q0 [$];                  // {valid, key} per accepted start
    logic [128:0]  exp_q1 [$];
    logic [128:0]  exp_0, exp_1;                // queue heads seen by the assertions
    int            pend_0, pend_1;
    logic          was_done_0, was_done_1;

    kb_verify_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic halt_fail();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        halt_fail();
    endtask

    task automatic value_fail(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
        halt_fail();
    endtask

    // retire a result once its done pulse is over, then refresh heads
    always @(negedge clk) begin
        if (was_done_0 && !done_0 && exp_q0.size() > 0) exp_q0.delete(0);
        if (was_done_1 && !done_1 && exp_q1.size() > 0) exp_q1.delete(0);
        was_done_0 = (done_0 === 1'b1);
        was_done_1 = (done_1 === 1'b1);
        pend_0     = exp_q0.size();
        pend_1     = exp_q1.size();
        exp_0      = (pend_0 > 0) ? exp_q0[0] : '0;
        exp_1      = (pend_1 > 0) ? exp_q1[0] : '0;
    end

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !(done_0 || valid_0 || done_1 || valid_1))
        else abort_run("done or valid high right after reset");

    a_pulse_0: assert property (@(posedge clk) disable iff (rst) done_0 |=> !done_0)
        else abort_run("done_0 lasted more than one cycle");
    a_pulse_1: assert property (@(posedge clk) disable iff (rst) done_1 |=> !done_1)
        else abort_run("done_1 lasted more than one cycle");
    a_vld_0: assert property (@(posedge clk) disable iff (rst) valid_0 |-> done_0)
        else abort_run("valid_0 high without done_0");
    a_vld_1: assert property (@(posedge clk) disable iff (rst) valid_1 |-> done_1)
        else abort_run("valid_1 high without done_1");
    a_owed_0: assert property (@(posedge clk) disable iff (rst) done_0 |-> pend_0 > 0)
        else abort_run("done_0 with no accepted start pending");
    a_owed_1: assert property (@(posedge clk) disable iff (rst) done_1 |-> pend_1 > 0)
        else abort_run("done_1 with no accepted start pending");
    a_valid_0: assert property (@(posedge clk) disable iff (rst) done_0 |-> valid_0 == exp_0[128])
        else value_fail("valid_0", 128'($sampled(valid_0)), 128'(exp_0[128]));
    a_valid_1: assert property (@(posedge clk) disable iff (rst) done_1 |-> valid_1 == exp_1[128])
        else value_fail("valid_1", 128'($sampled(valid_1)), 128'(exp_1[128]));
    a_key_0: assert property (@(posedge clk) disable iff (rst) done_0 |-> key_0 == exp_0[127:0])
        else value_fail("key_0", $sampled(key_0), exp_0[127:0]);
    a_key_1: assert property (@(posedge clk) disable iff (rst) done_1 |-> key_1 == exp_1[127:0])
        else value_fail("key_1", $sampled(key_1), exp_1[127:0]);

    // random key base; a good case carries the digest encrypted under itself
    task automatic make_case(input bit good, output logic [447:0] kb,
                             output logic [127:0] bv, output logic [128:0] exp);
        logic [127:0] dg;
        int           i;
        for (i = 0; i < 14; i++) kb[32*i +: 32] = $urandom;
        dg = md5_ref(kb);
        bv = enc_hash(dg);
        if (good) begin
            exp = {1'b1, dg};
        end else begin
            i     = $urandom_range(127, 0);
            bv[i] = ~bv[i];                     // one flipped bit spoils the match
            exp   = {1'b0, 128'h0};
        end
    endtask

    task automatic launch(input bit use0, input bit good0, input bit use1, input bit good1);
        logic [447:0] kb_a, kb_b;
        logic [127:0] bv_a, bv_b;
        logic [128:0] ex_a, ex_b;
        make_case(good0, kb_a, bv_a, ex_a);
        make_case(good1, kb_b, bv_b, ex_b);
        @(posedge clk);
        if (use0) begin
            start_0      <= 1'b1;
            kb_0         <= kb_a;
            in_buf_0.raw <= bv_a;
            exp_q0.push_back(ex_a);
        end
        if (use1) begin
            start_1      <= 1'b1;
            kb_1         <= kb_b;
            in_buf_1.raw <= bv_b;
            exp_q1.push_back(ex_b);
        end
        @(posedge clk);
        start_0 <= 1'b0;
        start_1 <= 1'b0;
    endtask

    // start on a busy lane 0, nothing expected from it
    task automatic poke_start();
        @(posedge clk);
        start_0          <= 1'b1;
        kb_0[31:0]       <= $urandom;
        in_buf_0.raw[31:0] <= $urandom;
        @(posedge clk);
        start_0 <= 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((exp_q0.size() > 0 || exp_q1.size() > 0) && n < 400) begin
            @(posedge clk);
            n++;
        end
        if (exp_q0.size() > 0 || exp_q1.size() > 0) abort_run("timeout waiting for done");
    endtask

    initial begin
        int k;
        void'($urandom(23647));
        rst      = 1'b1;
        stall    = 1'b0;
        start_0  = 1'b0;
        start_1  = 1'b0;
        kb_0     = '0;
        kb_1     = '0;
        in_buf_0 = '0;
        in_buf_1 = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        launch(1, 1, 0, 0);                     // good key on lane 0
        wait_idle();
        launch(1, 0, 0, 0);                     // bad key, lane 0
        wait_idle();
        launch(0, 0, 1, 1);
        wait_idle();
        launch(1, 1, 1, 0);                     // same-cycle starts
        wait_idle();
        launch(1, 0, 1, 1);                     // mixed the other way round
        wait_idle();

        for (k = 0; k < 4; k++) begin           // stall somewhere mid check
            launch(1, 1'($urandom_range(1, 0)), 1, 1'($urandom_range(1, 0)));
            repeat ($urandom_range(100, 0)) @(posedge clk);
            stall <= 1'b1;
            repeat ($urandom_range(50, 1)) @(posedge clk);
            stall <= 1'b0;
            wait_idle();
        end

        launch(1, 1, 0, 0);
        repeat (5) @(posedge clk);
        poke_start();                           // lands in load
        repeat (85) @(posedge clk);
        poke_start();                           // lands in decrypt
        wait_idle();
        repeat (150) @(posedge clk);            // a stray done trips a_owed_0

        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            abort_run("results still pending at end of run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* source/kb_verify_top.sv */
`timescale 1ns/1ps
`include "kb_verify_config.svh"

module kb_verify_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      start_0,
    input  logic [447:0]              kb_0,
    input  cipher_pkg::cipher_block_u in_buf_0,
    output logic [127:0]              key_0,
    output logic                      valid_0,
    output logic                      done_0,
    input  logic                      start_1,
    input  logic [447:0]              kb_1,
    input  cipher_pkg::cipher_block_u in_buf_1,
    output logic [127:0]              key_1,
    output logic                      valid_1,
    output logic                      done_1
);
    import cipher_pkg::*;

    wire  [`KB_LANES-1:0]       md5_req, md5_gnt;
    wire  [`KB_LANES-1:0]       lane_write, lane_start;
    wire  [`KB_LANES-1:0][3:0]  lane_waddr;
    wire  [`KB_LANES-1:0][31:0] lane_wdata;
    logic                       core_write, core_start, md5_done;
    logic [3:0]                 core_waddr;
    logic [31:0]                core_wdata;
    cipher_block_u              md5_digest;     // shared, each lane copies on done

    key_check u_lane0 (
        .clk(clk), .rst(rst), .stall(stall), .start(start_0), .kb(kb_0), .in_buf(in_buf_0),
        .key(key_0), .valid(valid_0), .done(done_0),
        .md5_req(md5_req[0]), .md5_gnt(md5_gnt[0]), .md5_write(lane_write[0]),
        .md5_waddr(lane_waddr[0]), .md5_wdata(lane_wdata[0]), .md5_start(lane_start[0]),
        .md5_done(md5_done), .md5_digest(md5_digest)
    );

    key_check u_lane1 (
        .clk(clk), .rst(rst), .stall(stall), .start(start_1), .kb(kb_1), .in_buf(in_buf_1),
        .key(key_1), .valid(valid_1), .done(done_1),
        .md5_req(md5_req[1]), .md5_gnt(md5_gnt[1]), .md5_write(lane_write[1]),
        .md5_waddr(lane_waddr[1]), .md5_wdata(lane_wdata[1]), .md5_start(lane_start[1]),
        .md5_done(md5_done), .md5_digest(md5_digest)
    );

    md5_arbiter u_arb (
        .clk(clk), .rst(rst), .req(md5_req), .gnt(md5_gnt),
        .lane_write(lane_write), .lane_waddr(lane_waddr), .lane_wdata(lane_wdata),
        .lane_start(lane_start), .write(core_write), .waddr(core_waddr),
        .wdata(core_wdata), .start(core_start)
    );

    md5_core u_md5 (
        .clk(clk), .rst(rst), .write(core_write), .waddr(core_waddr), .wdata(core_wdata),
        .start(core_start), .done(md5_done), .digest(md5_digest)
    );

endmodule

/* source/key_check.sv */
`timescale 1ns/1ps

module key_check (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      start,
    input  logic [447:0]              kb,
    input  cipher_pkg::cipher_block_u in_buf,
    output logic [127:0]              key,
    output logic                      valid,
    output logic                      done,
    output logic                      md5_req,
    input  logic                      md5_gnt,
    output logic                      md5_write,
    output logic [3:0]                md5_waddr,
    output logic [31:0]               md5_wdata,
    output logic                      md5_start,
    input  logic                      md5_done,
    input  cipher_pkg::cipher_block_u md5_digest
);
    import cipher_pkg::*;

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_REQ  = 3'd1;
    localparam logic [2:0] S_LOAD = 3'd2;
    localparam logic [2:0] S_HASH = 3'd3;
    localparam logic [2:0] S_DEC  = 3'd4;
    localparam logic [2:0] S_CMP  = 3'd5;

    logic [2:0]    state;
    logic [4:0]    cnt;                         // next word to stream, 16 means all sent
    logic [447:0]  kb_q;
    cipher_block_u buf_q;                       // encrypted hash
    cipher_block_u hash_q;                      // digest, also the cipher key
    logic [63:0]   pt0, pt1;                    // plaintext blocks
    logic [1:0]    rdy;
    logic          go;
    logic          match;

    // padded block, kb slice 0 is word 0
    function automatic logic [31:0] pad_word(input logic [3:0] idx);
        if (idx == 4'd15) return 32'h8000_0000;
        if (idx == 4'd14) return 32'h0;
        return kb_q[32*idx +: 32];
    endfunction

    assign go    = (state == S_HASH) && md5_done && !stall; // digest lands as ciphers load
    assign match = ({pt1, pt0} == hash_q.raw);

    xtea_decrypt u_xtea0 (
        .clk(clk), .rst(rst), .stall(stall), .go(go), .key(hash_q),
        .block_in(buf_q.raw[63:0]), .block_out(pt0), .ready(rdy[0])
    );

    xtea_decrypt u_xtea1 (
        .clk(clk), .rst(rst), .stall(stall), .go(go), .key(hash_q),
        .block_in(buf_q.raw[127:64]), .block_out(pt1), .ready(rdy[1])
    );

    always_ff @(posedge clk) begin
        if (!stall && state == S_IDLE && start) begin
            kb_q  <= kb;
            buf_q <= in_buf;
        end
        if (go) begin
            hash_q <= md5_digest;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            cnt       <= '0;
            md5_req   <= 1'b0;
            md5_write <= 1'b0;
            md5_waddr <= '0;
            md5_wdata <= '0;
            md5_start <= 1'b0;
            done      <= 1'b0;
            valid     <= 1'b0;
            key       <= '0;
        end else begin
            md5_write <= 1'b0;                  // pulses drop even under stall
            md5_start <= 1'b0;
            done      <= 1'b0;
            valid     <= 1'b0;
            if (!stall) begin
                case (state)
                    S_IDLE: if (start) begin
                        md5_req <= 1'b1;
                        state   <= S_REQ;
                    end
                    S_REQ: if (md5_gnt) begin   // first word right on grant
                        md5_write <= 1'b1;
                        md5_waddr <= 4'd0;
                        md5_wdata <= pad_word(4'd0);
                        cnt       <= 5'd1;
                        state     <= S_LOAD;
                    end
                    S_LOAD: if (cnt[4]) begin
                        md5_start <= 1'b1;
                        state     <= S_HASH;
                    end else begin
                        md5_write <= 1'b1;
                        md5_waddr <= cnt[3:0];
                        md5_wdata <= pad_word(cnt[3:0]);
                        cnt       <= cnt + 5'd1;
                    end
                    S_HASH: if (md5_done) begin
                        md5_req <= 1'b0;        // core free for the other lane
                        state   <= S_DEC;
                    end
                    S_DEC: if (&rdy) begin
                        done  <= 1'b1;
                        valid <= match;
                        key   <= match ? hash_q.raw : 128'h0;
                        state <= S_CMP;
                    end
                    S_CMP: state <= S_IDLE;     // result cycle
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    a_valid_done: assert property (@(posedge clk) disable iff (rst) valid |-> done)
        else $error("key_check: valid without done");

    // the arbiter must route this lane before it drives the core
    a_write_granted: assert property (@(posedge clk) disable iff (rst)
        (md5_write || md5_start) |-> md5_gnt)
        else $error("key_check: md5 access without grant");

endmodule

/* source/xtea_decrypt.sv */
`timescale 1ns/1ps
`include "kb_verify_config.svh"

module xtea_decrypt (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      go,
    input  cipher_pkg::cipher_block_u key,
    input  logic [63:0]               block_in,
    output logic [63:0]               block_out,
    output logic                      ready
);
    import cipher_pkg::*;

    localparam int          ROUNDS   = `XTEA_ROUNDS;
    localparam int          CW       = $clog2(ROUNDS + 1);
    localparam logic [31:0] SUM_INIT = 32'(xtea_delta * ROUNDS); // sum after last enc round

    logic [31:0]   v0, v1, sum;
    logic [CW-1:0] cnt;
    logic          busy;
    logic [31:0]   v1_next, sum_next, v0_next;

    // inverse round, v1 first then v0 with the stepped sum
    always_comb begin
        v1_next  = v1 - ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + key.w[sum[12:11]]));
        sum_next = sum - xtea_delta;
        v0_next  = v0 - ((((v1_next << 4) ^ (v1_next >> 5)) + v1_next)
                         ^ (sum_next + key.w[sum_next[1:0]]));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            ready <= 1'b0;
            cnt   <= '0;
        end else if (!stall) begin
            ready <= 1'b0;                      // one unstalled cycle wide
            if (go) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(ROUNDS - 1)) begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (go) begin
                v0  <= block_in[31:0];
                v1  <= block_in[63:32];
                sum <= SUM_INIT;
            end else if (busy) begin
                v0  <= v0_next;
                v1  <= v1_next;
                sum <= sum_next;
            end
        end
    end

    assign block_out = {v1, v0};                // held after the last round

endmodule

/* source/md5_arbiter.sv */
`timescale 1ns/1ps
`include "kb_verify_config.svh"

module md5_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`KB_LANES-1:0]        req,
    output logic [`KB_LANES-1:0]        gnt,
    input  logic [`KB_LANES-1:0]        lane_write,
    input  logic [`KB_LANES-1:0][3:0]   lane_waddr,
    input  logic [`KB_LANES-1:0][31:0]  lane_wdata,
    input  logic [`KB_LANES-1:0]        lane_start,
    output logic                        write,
    output logic [3:0]                  waddr,
    output logic [31:0]                 wdata,
    output logic                        start
);
    localparam int N  = `KB_LANES;
    localparam int IW = (N > 1) ? $clog2(N) : 1;

    logic [IW-1:0] owner;                       // index of granted lane
    logic [IW-1:0] ptr;                         // round robin start point
    logic [IW-1:0] pick;
    logic          found;
    logic          free;

    assign free = ~|(gnt & req);                // no owner or owner let go

    // first requester at or after ptr
    always_comb begin
        int idx;
        pick  = ptr;
        found = 1'b0;
        for (int i = 0; i < N; i++) begin
            idx = (int'(ptr) + i) % N;
            if (!found && req[idx]) begin
                pick  = IW'(idx);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gnt   <= '0;
            owner <= '0;
            ptr   <= '0;
        end else if (free) begin
            gnt <= '0;
            if (found) begin
                gnt[pick] <= 1'b1;
                owner     <= pick;
                ptr       <= (int'(pick) == N - 1) ? '0 : pick + 1'b1;
            end
        end
    end

    assign write = |(gnt & lane_write);         // only the owner reaches the core
    assign start = |(gnt & lane_start);
    assign waddr = lane_waddr[owner];
    assign wdata = lane_wdata[owner];

    a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
        else $error("md5_arbiter: more than one grant");

endmodule

/* source/md5_core.sv */
`timescale 1ns/1ps

module md5_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      write,
    input  logic [3:0]                waddr,
    input  logic [31:0]               wdata,
    input  logic                      start,
    output logic                      done,
    output cipher_pkg::cipher_block_u digest
);
    import md5_pkg::*;

    logic [31:0] msg [16];                      // message block
    logic [31:0] a, b, c, d;                    // working state, digest after last round
    logic [5:0]  rnd;                           // round 0..63
    logic        busy;
    logic [31:0] f;
    logic [31:0] t;
    logic [63:0] rot;
    logic [31:0] b_next;

    // one md5 step
    always_comb begin
        case (rnd[5:4])
            2'd0:    f = (b & c) | (~b & d);
            2'd1:    f = (d & b) | (~d & c);
            2'd2:    f = b ^ c ^ d;
            default: f = c ^ (b | ~d);
        endcase
        t      = a + f + md5_k(rnd) + msg[md5_g(rnd)];
        rot    = {t, t} << md5_s(rnd);           // upper half is rotl(t, s)
        b_next = b + rot[63:32];
    end

    always_ff @(posedge clk) begin
        if (write) begin
            msg[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            rnd  <= '0;
        end else begin
            if (write) begin
                done <= 1'b0;                   // new message, old digest gone
            end
            if (start && !busy) begin
                busy <= 1'b1;
                rnd  <= '0;
            end else if (busy) begin
                rnd <= rnd + 6'd1;
                if (rnd == 6'd63) begin
                    busy <= 1'b0;
                    done <= 1'b1;               // held until next write
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            a <= md5_iv[0];
            b <= md5_iv[1];
            c <= md5_iv[2];
            d <= md5_iv[3];
        end else if (busy) begin
            if (rnd == 6'd63) begin             // last step folds in the iv
                a <= d + md5_iv[0];
                b <= b_next + md5_iv[1];
                c <= b + md5_iv[2];
                d <= c + md5_iv[3];
            end else begin
                a <= d;
                b <= b_next;
                c <= b;
                d <= c;
            end
        end
    end

    assign digest.raw = {d, c, b, a};           // A in w[0]

    // the owning lane must not touch the message mid-run
    a_no_write_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !write)
        else $error("md5_core: message write during a run");

endmodule

/* source/cipher_pkg.sv */
package cipher_pkg;

    // xtea key schedule constant
    localparam logic [31:0] xtea_delta = 32'h9e37_79b9;

    // 128-bit block, key or digest
    // w[0] sits in the low bits, block 0 is w[0]/w[1], block 1 is w[2]/w[3]
    typedef union packed {
        logic [127:0]      raw;                 // whole word, for compare and output
        logic [3:0][31:0]  w;                   // xtea key words / md5 A..D
    } cipher_block_u;

endpackage

/* source/md5_pkg.sv */
package md5_pkg;

    // chaining init, word 0 is A
    localparam logic [3:0][31:0] md5_iv = {
        32'h1032_5476, 32'h98ba_dcfe, 32'hefcd_ab89, 32'h6745_2301
    };

    // floor(abs(sin(i + 1)) * 2^32)
    localparam logic [31:0] md5_k_tab [0:63] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // rotate amounts, four per round group
    localparam logic [4:0] md5_s_tab [0:15] = '{
        7, 12, 17, 22,
        5, 9, 14, 20,
        4, 11, 16, 23,
        6, 10, 15, 21
    };

    function automatic logic [31:0] md5_k(input logic [5:0] i);
        return md5_k_tab[i];
    endfunction

    function automatic logic [4:0] md5_s(input logic [5:0] i);
        return md5_s_tab[{i[5:4], i[1:0]}]; // group, then step mod 4
    endfunction

    // message word used by round i
    function automatic logic [3:0] md5_g(input logic [5:0] i);
        logic [3:0] j;
        j = i[3:0];                         // all products taken mod 16
        case (i[5:4])
            2'd0:    return j;
            2'd1:    return 4'(5 * j + 1);
            2'd2:    return 4'(3 * j + 5);
            default: return 4'(7 * j);
        endcase
    endfunction

endpackage

/* source/kb_verify_config.svh */
`ifndef KB_VERIFY_CONFIG_SVH
`define KB_VERIFY_CONFIG_SVH

// lanes sharing one md5 core
`define KB_LANES 2

// xtea rounds per block decrypt
`define XTEA_ROUNDS 32

`endif
